// ==== vlog.f ====
design/psx_host_pkg.sv
design/card_event_if.sv
design/download_packer.sv
design/card_event_decoder.sv
design/memcard_slot.sv
design/card_request_arbiter.sv
design/psx_host_bridge.sv
verification/tb_clock_gen.sv
verification/psx_host_bridge_asserts.sv
verification/psx_host_bridge_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the host bridge testbench with Verilator.
# The run fails when the log holds the fail message or a step returns an error.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f vlog.f --top-module psx_host_bridge_tb \
	-o psx_host_bridge_sim
if [ $? -ne 0 ]; then
	echo "Build failed"
	exit 1
fi

./obj_dir/psx_host_bridge_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "ERRORS FOUND" "$LOG"; then
	echo "Simulation failed"
	exit 1
fi
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

echo "Simulation passed"
exit 0

// ==== verification/psx_host_bridge_tb.sv ====
// Table-driven testbench for psx_host_bridge with two memory cards.
// RAM writes and card requests are compared in order against expected queues.
// ram_ready and card_ready stall at random; the first mismatch stops the run.

module psx_host_bridge_tb;

	localparam int NUM_CARDS  = 2;
	localparam int IDX_W      = 1;
	localparam int AW         = psx_host_pkg::IOCTL_ADDR_W;
	localparam int NUM_STEPS  = 24;
	localparam int MAX_CYCLES = NUM_STEPS * 40;

	typedef enum logic [3:0] {
		ST_DL_START, ST_WORD, ST_KEY, ST_DL_END, ST_MOUNT,
		ST_SAVE, ST_AUTOSAVE, ST_LOAD, ST_HOLD
	} step_op_t;

	typedef struct packed {
		step_op_t             op;
		logic [7:0]           index;
		logic [AW-1:0]        addr;
		logic [31:0]          data;
		logic [NUM_CARDS-1:0] mask;
		logic [63:0]          size;
	} step_t;

	typedef struct packed {
		logic [AW-1:0] addr;
		logic [31:0]   data;
	} ram_wr_t;

	typedef struct packed {
		logic [IDX_W-1:0]       index;
		psx_host_pkg::card_op_t op;
	} card_req_t;

	// ========================================================================
	// Step table
	// ========================================================================
	// Word rows give the low half address and {high, low} data
	step_t steps [NUM_STEPS] = '{
		'{ST_DL_START, 8'd0,   27'h0000000, 32'h0,        2'b00, 64'h0},
		'{ST_WORD,     8'd0,   27'h0000000, 32'ha1b2c3d4, 2'b00, 64'h0},
		'{ST_WORD,     8'd0,   27'h0000004, 32'h11223344, 2'b00, 64'h0},
		'{ST_WORD,     8'd0,   27'h0000008, 32'hdeadbeef, 2'b00, 64'h0},
		'{ST_DL_END,   8'd0,   27'h0000000, 32'h0,        2'b00, 64'h0},
		'{ST_DL_START, 8'd1,   27'h0000000, 32'h0,        2'b00, 64'h0},
		'{ST_WORD,     8'd0,   27'h0000000, 32'h3c1a8001, 2'b00, 64'h0},
		'{ST_WORD,     8'd0,   27'h0000100, 32'h27bdfff0, 2'b00, 64'h0},
		'{ST_DL_END,   8'd0,   27'h0000000, 32'h0,        2'b00, 64'h0},
		// CD index with upper bits set, only the low six bits select it
		'{ST_DL_START, 8'h42,  27'h0000000, 32'h0,        2'b00, 64'h0},
		'{ST_WORD,     8'd0,   27'h0000000, 32'h00ffffff, 2'b00, 64'h0},
		'{ST_WORD,     8'd0,   27'h0001ffc, 32'h0badf00d, 2'b00, 64'h0},
		'{ST_DL_END,   8'd0,   27'h0000000, 32'h0,        2'b00, 64'h0},
		'{ST_DL_START, 8'd250, 27'h0000000, 32'h0,        2'b00, 64'h0},
		'{ST_KEY,      8'd0,   27'h0000000, 32'h0000beef, 2'b00, 64'h0},
		'{ST_DL_END,   8'd0,   27'h0000000, 32'h0,        2'b00, 64'h0},
		'{ST_MOUNT,    8'd0,   27'h0000000, 32'h0,        2'b11, 64'h20000},
		'{ST_SAVE,     8'd0,   27'h0000000, 32'h0,        2'b00, 64'h0},
		'{ST_AUTOSAVE, 8'd0,   27'h0000000, 32'h0,        2'b00, 64'h0},
		'{ST_LOAD,     8'd0,   27'h0000000, 32'h0,        2'b00, 64'h0},
		'{ST_MOUNT,    8'd0,   27'h0000000, 32'h0,        2'b10, 64'h0},
		'{ST_SAVE,     8'd0,   27'h0000000, 32'h0,        2'b00, 64'h0},
		'{ST_MOUNT,    8'd0,   27'h0000000, 32'h0,        2'b10, 64'h20000},
		'{ST_HOLD,     8'd0,   27'h0000000, 32'h0,        2'b00, 64'h0}
	};

	logic                                  clk_1x;
	logic                                  arst_n;
	logic                                  ioctl_download;
	logic [7:0]                            ioctl_index;
	logic [AW-1:0]                         ioctl_addr;
	logic [psx_host_pkg::IOCTL_DATA_W-1:0] ioctl_dout;
	logic                                  ioctl_wr;
	logic                                  ram_ready = 1'b0;
	logic [NUM_CARDS-1:0]                  img_mounted;
	logic [psx_host_pkg::IMG_SIZE_W-1:0]   img_size;
	logic                                  bk_load;
	logic                                  bk_save;
	logic                                  osd_open;
	logic                                  autosave;
	logic                                  card_ready = 1'b0;
	logic                                  ioctl_wait;
	logic                                  ram_valid;
	logic [AW-1:0]                         ram_addr;
	logic [psx_host_pkg::RAM_DATA_W-1:0]   ram_data;
	logic                                  load_exe;
	logic                                  has_cd;
	logic [AW-1:0]                         cd_size;
	logic [psx_host_pkg::IOCTL_DATA_W-1:0] libcrypt_key;
	logic [NUM_CARDS-1:0]                  mounted;
	logic                                  card_valid;
	logic [IDX_W-1:0]                      card_index;
	psx_host_pkg::card_op_t                card_op;

	// Scoreboard, filled by the stimulus and read by the monitor
	ram_wr_t                exp_ram [$];
	card_req_t              exp_card [$];
	int                     ram_rd = 0;
	int                     card_rd = 0;
	int                     seed = 32'h706b92ff;
	int                     cycles = 0;
	int                     exe_pulses = 0;
	int                     exp_exe_pulses = 0;
	logic                   hold_card = 1'b0;
	logic [NUM_CARDS-1:0]   mounted_model = '0;
	psx_host_pkg::dl_kind_t kind = psx_host_pkg::DL_NONE;
	logic [AW-1:0]          base = '0;
	logic [AW-1:0]          last_addr = '0;
	logic [15:0]            exp_key = '0;
	logic                   cd_done = 1'b0;
	logic                   wr_pend = 1'b0;
	logic                   ram_stall = 1'b0;
	logic                   ram_done = 1'b0;
	logic                   card_stall = 1'b0;
	ram_wr_t                ram_held;
	card_req_t              card_held;

	tb_clock_gen u_clock (
		.clk_1x (clk_1x),
		.arst_n (arst_n)
	);

	psx_host_bridge #(
		.NUM_CARDS (NUM_CARDS)
	) dut_i (
		.clk_1x         (clk_1x),
		.arst_n         (arst_n),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.ioctl_wr       (ioctl_wr),
		.ram_ready      (ram_ready),
		.img_mounted    (img_mounted),
		.img_size       (img_size),
		.bk_load        (bk_load),
		.bk_save        (bk_save),
		.osd_open       (osd_open),
		.autosave       (autosave),
		.card_ready     (card_ready),
		.ioctl_wait     (ioctl_wait),
		.ram_valid      (ram_valid),
		.ram_addr       (ram_addr),
		.ram_data       (ram_data),
		.load_exe       (load_exe),
		.has_cd         (has_cd),
		.cd_size        (cd_size),
		.libcrypt_key   (libcrypt_key),
		.mounted        (mounted),
		.card_valid     (card_valid),
		.card_index     (card_index),
		.card_op        (card_op)
	);

	task automatic stop_on_error();
		$display("ERRORS FOUND");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic report_value(input string name, input logic [63:0] exp,
		input logic [63:0] act);
		$display("ERROR: %s expected 0x%0h actual 0x%0h", name, exp, act);
		stop_on_error();
	endtask

	task automatic report_text(input string msg);
		$display("%s", msg);
		stop_on_error();
	endtask

	// Download kind from the host index
	function automatic psx_host_pkg::dl_kind_t kind_of(input logic [7:0] index);
		if (index == psx_host_pkg::IDX_BIOS)
			return psx_host_pkg::DL_BIOS;
		if (index == psx_host_pkg::IDX_EXE)
			return psx_host_pkg::DL_EXE;
		if (index[5:0] == psx_host_pkg::IDX_CD)
			return psx_host_pkg::DL_CD;
		if (index == psx_host_pkg::IDX_SBI)
			return psx_host_pkg::DL_SBI;
		return psx_host_pkg::DL_NONE;
	endfunction

	// Random stalls on both ready inputs
	always @(posedge clk_1x) begin
		ram_ready  <= ($random(seed) & 32'h3) != 32'h0;
		card_ready <= !hold_card && (($random(seed) & 32'h1) != 32'h0);
	end

	// ========================================================================
	// Monitor
	// ========================================================================
	always @(posedge clk_1x) begin
		cycles++;
		if (cycles >= MAX_CYCLES)
			report_text($sformatf("Timeout: run not done after %0d cycles", cycles));
		if (arst_n) begin
			// Pending from the sampled high half until RAM takes the word
			assert (ioctl_wait == wr_pend)
				else report_value("ioctl_wait", 64'(wr_pend), 64'(ioctl_wait));
			assert (ram_valid == wr_pend)
				else report_value("ram_valid", 64'(wr_pend), 64'(ram_valid));
			if (ram_done)
				assert (!ioctl_wait)
					else report_text("ioctl_wait stayed high after the RAM write was taken");
			if (ram_stall)
				assert (ram_valid && ram_addr == ram_held.addr && ram_data == ram_held.data)
					else report_text("RAM write changed while ram_ready was low");
			if (card_stall)
				assert (card_valid && card_index == card_held.index && card_op == card_held.op)
					else report_text("Card request changed while card_ready was low");
			if (ram_valid && ram_ready) begin
				assert (ram_rd < exp_ram.size())
					else report_text("RAM write without a pending host word pair");
				assert (ram_addr == exp_ram[ram_rd].addr)
					else report_value("ram_addr", 64'(exp_ram[ram_rd].addr), 64'(ram_addr));
				assert (ram_data == exp_ram[ram_rd].data)
					else report_value("ram_data", 64'(exp_ram[ram_rd].data), 64'(ram_data));
				ram_rd++;
			end
			if (card_valid && card_ready) begin
				assert (card_rd < exp_card.size())
					else report_text("Card request that no event asked for");
				assert (card_index == exp_card[card_rd].index)
					else report_value("card_index", 64'(exp_card[card_rd].index),
						64'(card_index));
				assert (card_op == exp_card[card_rd].op)
					else report_value("card_op", 64'(exp_card[card_rd].op), 64'(card_op));
				card_rd++;
			end
			if (load_exe) begin
				assert (exe_pulses < exp_exe_pulses)
					else report_text("load_exe pulsed with no executable download ended");
				exe_pulses++;
			end
			if (wr_pend && ram_ready)
				wr_pend = 1'b0;
			else if (ioctl_wr && ioctl_addr[1] && kind != psx_host_pkg::DL_SBI &&
				kind != psx_host_pkg::DL_NONE)
				wr_pend = 1'b1;
			ram_done   = ram_valid && ram_ready;
			ram_stall  = ram_valid && !ram_ready;
			ram_held   = {ram_addr, ram_data};
			card_stall = card_valid && !card_ready;
			card_held  = {card_index, card_op};
		end
	end

	// ========================================================================
	// Stimulus tasks
	// ========================================================================
	task automatic host_write(input logic [AW-1:0] addr, input logic [15:0] dout);
		@(negedge clk_1x);
		while (ioctl_wait)
			@(negedge clk_1x);
		@(posedge clk_1x);
		ioctl_wr   <= 1'b1;
		ioctl_addr <= addr;
		ioctl_dout <= dout;
		@(posedge clk_1x);
		ioctl_wr <= 1'b0;
	endtask

	task automatic write_word(input logic [AW-1:0] addr, input logic [31:0] data);
		host_write(addr, data[15:0]);
		host_write(addr + AW'(2), data[31:16]);
		exp_ram.push_back({addr + base, data});
		last_addr = addr + AW'(2);
		@(negedge clk_1x);
		assert (ioctl_wait)
			else report_text("ioctl_wait did not rise after the high half");
	endtask

	task automatic end_download();
		@(posedge clk_1x);
		ioctl_download <= 1'b0;
		if (kind == psx_host_pkg::DL_EXE)
			exp_exe_pulses++;
		if (kind == psx_host_pkg::DL_CD)
			cd_done = 1'b1;
		repeat (5) @(posedge clk_1x);
		@(negedge clk_1x);
		assert (exe_pulses == exp_exe_pulses)
			else report_value("load_exe pulses", 64'(exp_exe_pulses), 64'(exe_pulses));
		assert (has_cd == cd_done)
			else report_value("has_cd", 64'(cd_done), 64'(has_cd));
		if (kind == psx_host_pkg::DL_CD)
			assert (cd_size == last_addr)
				else report_value("cd_size", 64'(last_addr), 64'(cd_size));
		if (kind == psx_host_pkg::DL_SBI)
			assert (libcrypt_key == exp_key)
				else report_value("libcrypt_key", 64'(exp_key), 64'(libcrypt_key));
	endtask

	task automatic mount_cards(input logic [NUM_CARDS-1:0] mask, input logic [63:0] size);
		card_req_t req;
		@(posedge clk_1x);
		img_mounted <= mask;
		img_size    <= size;
		for (int i = 0; i < NUM_CARDS; i++) begin
			if (mask[i]) begin
				mounted_model[i] = (size != 64'h0);
				if (size != 64'h0) begin
					req.index = IDX_W'(i);
					req.op    = psx_host_pkg::CARD_LOAD;
					exp_card.push_back(req);
				end
			end
		end
		@(posedge clk_1x);
		img_mounted <= '0;
		repeat (3) @(posedge clk_1x);
		@(negedge clk_1x);
		assert (mounted == mounted_model)
			else report_value("mounted", 64'(mounted_model), 64'(mounted));
	endtask

	// One request per mounted card, lowest card first
	task automatic pulse_command(input step_op_t op);
		card_req_t req;
		@(posedge clk_1x);
		case (op)
			ST_SAVE: bk_save <= 1'b1;
			ST_LOAD: bk_load <= 1'b1;
			default: begin
				autosave <= 1'b1;
				osd_open <= 1'b1;
			end
		endcase
		for (int i = 0; i < NUM_CARDS; i++) begin
			if (mounted_model[i]) begin
				req.index = IDX_W'(i);
				req.op    = (op == ST_LOAD) ? psx_host_pkg::CARD_LOAD : psx_host_pkg::CARD_SAVE;
				exp_card.push_back(req);
			end
		end
		@(posedge clk_1x);
		bk_save  <= 1'b0;
		bk_load  <= 1'b0;
		osd_open <= 1'b0;
	endtask

	task automatic hold_card_requests();
		@(posedge clk_1x);
		hold_card <= 1'b1;
		@(posedge clk_1x);
		pulse_command(ST_SAVE);
		repeat (3) @(posedge clk_1x);
		pulse_command(ST_LOAD);
		repeat (6) @(posedge clk_1x);
		@(negedge clk_1x);
		// Output still shows the first request
		assert (card_valid)
			else report_text("card_valid fell while requests waited under back-pressure");
		assert (card_index == exp_card[card_rd].index)
			else report_value("card_index", 64'(exp_card[card_rd].index), 64'(card_index));
		assert (card_op == exp_card[card_rd].op)
			else report_value("card_op", 64'(exp_card[card_rd].op), 64'(card_op));
		@(posedge clk_1x);
		hold_card <= 1'b0;
	endtask

	task automatic wait_idle();
		@(negedge clk_1x);
		while (ram_rd < exp_ram.size() || card_rd < exp_card.size() || ram_valid || card_valid)
			@(negedge clk_1x);
	endtask

	// ========================================================================
	// Main sequence
	// ========================================================================
	initial begin
		step_t st;
		ioctl_download <= 1'b0;
		ioctl_index    <= 8'd0;
		ioctl_addr     <= '0;
		ioctl_dout     <= '0;
		ioctl_wr       <= 1'b0;
		img_mounted    <= '0;
		img_size       <= '0;
		bk_load        <= 1'b0;
		bk_save        <= 1'b0;
		osd_open       <= 1'b0;
		autosave       <= 1'b0;
		@(posedge arst_n);
		@(posedge clk_1x);
		for (int s = 0; s < NUM_STEPS; s++) begin
			st = steps[s];
			case (st.op)
				ST_DL_START: begin
					kind = kind_of(st.index);
					if (kind == psx_host_pkg::DL_BIOS)
						base = psx_host_pkg::BIOS_START;
					else if (kind == psx_host_pkg::DL_EXE)
						base = psx_host_pkg::EXE_START;
					else
						base = '0;
					@(posedge clk_1x);
					ioctl_download <= 1'b1;
					ioctl_index    <= st.index;
				end
				ST_WORD: write_word(st.addr, st.data);
				ST_KEY: begin
					exp_key = st.data[15:0];
					host_write(st.addr, st.data[15:0]);
				end
				ST_DL_END: end_download();
				ST_MOUNT: mount_cards(st.mask, st.size);
				ST_HOLD: hold_card_requests();
				default: pulse_command(st.op);
			endcase
			wait_idle();
		end
		// Room for any stray request to show up
		repeat (10) @(posedge clk_1x);
		$display("NO ERRORS");
		$finish;
	end

endmodule

// ==== verification/psx_host_bridge_asserts.sv ====
// Handshake checks on the RAM write and card request outputs.
// Valid and payload must hold while ready is low.
// Bound into every psx_host_bridge instance.

module psx_host_bridge_asserts #(
	parameter int IDX_W = 1
) (
	input logic                                  clk_1x,
	input logic                                  arst_n,
	input logic                                  ioctl_wait,
	input logic                                  ram_valid,
	input logic                                  ram_ready,
	input logic [psx_host_pkg::IOCTL_ADDR_W-1:0] ram_addr,
	input logic [psx_host_pkg::RAM_DATA_W-1:0]   ram_data,
	input logic                                  card_valid,
	input logic                                  card_ready,
	input logic [IDX_W-1:0]                      card_index,
	input psx_host_pkg::card_op_t                card_op
);

	ram_hold: assert property (@(posedge clk_1x) disable iff (!arst_n)
		ram_valid && !ram_ready |=> ram_valid && $stable(ram_addr) && $stable(ram_data))
		else $error("RAM write dropped or changed while ram_ready was low");

	card_hold: assert property (@(posedge clk_1x) disable iff (!arst_n)
		card_valid && !card_ready |=> card_valid && $stable(card_index) && $stable(card_op))
		else $error("Card request dropped or changed while card_ready was low");

	// Host stall mirrors the pending RAM write
	wait_match: assert property (@(posedge clk_1x) disable iff (!arst_n)
		ioctl_wait == ram_valid)
		else $error("ioctl_wait differs from ram_valid");

endmodule

bind psx_host_bridge psx_host_bridge_asserts #(
	.IDX_W (IDX_W)
) u_asserts (
	.clk_1x     (clk_1x),
	.arst_n     (arst_n),
	.ioctl_wait (ioctl_wait),
	.ram_valid  (ram_valid),
	.ram_ready  (ram_ready),
	.ram_addr   (ram_addr),
	.ram_data   (ram_data),
	.card_valid (card_valid),
	.card_ready (card_ready),
	.card_index (card_index),
	.card_op    (card_op)
);

// ==== verification/tb_clock_gen.sv ====
// Free-running clk_1x with a period of 20 time units.
// arst_n is low over the first 3 rising edges and is released after the third.

module tb_clock_gen (
	output logic clk_1x,
	output logic arst_n
);

	localparam int HALF_PERIOD = 10;

	initial begin
		clk_1x = 1'b0;
		forever #HALF_PERIOD clk_1x = ~clk_1x;
	end

	initial begin
		arst_n = 1'b0;
		repeat (3) @(posedge clk_1x);
		arst_n <= 1'b1;
	end

endmodule

// ==== design/psx_host_bridge.sv ====
// Host-side glue of the console core: download packing and card requests.
// All logic runs on clk_1x with asynchronous active-low reset arst_n.
// NUM_CARDS may be any value of 1 or more.

module psx_host_bridge #(
	parameter  int NUM_CARDS = 2,
	localparam int IDX_W     = (NUM_CARDS > 1) ? $clog2(NUM_CARDS) : 1
) (
	input  logic                                  clk_1x,
	input  logic                                  arst_n,
	input  logic                                  ioctl_download,
	input  logic [7:0]                            ioctl_index,
	input  logic [psx_host_pkg::IOCTL_ADDR_W-1:0] ioctl_addr,
	input  logic [psx_host_pkg::IOCTL_DATA_W-1:0] ioctl_dout,
	input  logic                                  ioctl_wr,
	input  logic                                  ram_ready,
	input  logic [NUM_CARDS-1:0]                  img_mounted,
	input  logic [psx_host_pkg::IMG_SIZE_W-1:0]   img_size,
	input  logic                                  bk_load,
	input  logic                                  bk_save,
	input  logic                                  osd_open,
	input  logic                                  autosave,
	input  logic                                  card_ready,
	output logic                                  ioctl_wait,
	output logic                                  ram_valid,
	output logic [psx_host_pkg::IOCTL_ADDR_W-1:0] ram_addr,
	output logic [psx_host_pkg::RAM_DATA_W-1:0]   ram_data,
	output logic                                  load_exe,
	output logic                                  has_cd,
	output logic [psx_host_pkg::IOCTL_ADDR_W-1:0] cd_size,
	output logic [psx_host_pkg::IOCTL_DATA_W-1:0] libcrypt_key,
	output logic [NUM_CARDS-1:0]                  mounted,
	output logic                                  card_valid,
	output logic [IDX_W-1:0]                      card_index,
	output psx_host_pkg::card_op_t                card_op
);

	logic [NUM_CARDS-1:0]   slot_valid;
	logic [NUM_CARDS-1:0]   slot_ready;
	psx_host_pkg::card_op_t slot_op [NUM_CARDS];

	card_event_if ev_if [NUM_CARDS] ();

	// ========================================================================
	// Download path
	// ========================================================================
	download_packer u_packer (
		.clk_1x         (clk_1x),
		.arst_n         (arst_n),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.ioctl_wr       (ioctl_wr),
		.ram_ready      (ram_ready),
		.ioctl_wait     (ioctl_wait),
		.ram_valid      (ram_valid),
		.ram_addr       (ram_addr),
		.ram_data       (ram_data),
		.load_exe       (load_exe),
		.has_cd         (has_cd),
		.cd_size        (cd_size),
		.libcrypt_key   (libcrypt_key)
	);

	// ========================================================================
	// Memory-card control
	// ========================================================================
	card_event_decoder #(
		.NUM_CARDS (NUM_CARDS)
	) u_decoder (
		.clk_1x      (clk_1x),
		.arst_n      (arst_n),
		.img_mounted (img_mounted),
		.img_size    (img_size),
		.bk_load     (bk_load),
		.bk_save     (bk_save),
		.osd_open    (osd_open),
		.autosave    (autosave),
		.ev          (ev_if)
	);

	for (genvar i = 0; i < NUM_CARDS; i++) begin : g_slot
		memcard_slot u_slot (
			.clk_1x    (clk_1x),
			.arst_n    (arst_n),
			.req_ready (slot_ready[i]),
			.ev        (ev_if[i]),
			.req_valid (slot_valid[i]),
			.req_op    (slot_op[i]),
			.mounted   (mounted[i])
		);
	end

	card_request_arbiter #(
		.NUM_CARDS (NUM_CARDS)
	) u_arbiter (
		.clk_1x     (clk_1x),
		.arst_n     (arst_n),
		.req_valid  (slot_valid),
		.req_op     (slot_op),
		.card_ready (card_ready),
		.req_ready  (slot_ready),
		.card_valid (card_valid),
		.card_index (card_index),
		.card_op    (card_op)
	);

endmodule

// ==== design/card_request_arbiter.sv ====
// Round-robin merge of slot requests into a single output register.
// The pointer starts at slot 0 and moves past each granted slot.
// Under back-pressure no slot is granted and the output holds.

module card_request_arbiter #(
	parameter  int NUM_CARDS = 2,
	localparam int IDX_W     = (NUM_CARDS > 1) ? $clog2(NUM_CARDS) : 1
) (
	input  logic                   clk_1x,
	input  logic                   arst_n,
	input  logic [NUM_CARDS-1:0]   req_valid,
	input  psx_host_pkg::card_op_t req_op [NUM_CARDS],
	input  logic                   card_ready,
	output logic [NUM_CARDS-1:0]   req_ready,
	output logic                   card_valid,
	output logic [IDX_W-1:0]       card_index,
	output psx_host_pkg::card_op_t card_op
);

	logic [IDX_W-1:0] ptr;
	logic [IDX_W-1:0] grant_idx;
	logic             grant_found;
	logic             load_en;

	// Output register is free, or drains this cycle
	assign load_en = !card_valid || card_ready;

	// ========================================================================
	// First valid slot at or after the pointer
	// ========================================================================
	always_comb begin
		int j;
		grant_found = 1'b0;
		grant_idx   = '0;
		for (int k = 0; k < NUM_CARDS; k++) begin
			j = int'(ptr) + k;
			if (j >= NUM_CARDS)
				j = j - NUM_CARDS;
			if (!grant_found && req_valid[j]) begin
				grant_found = 1'b1;
				grant_idx   = IDX_W'(j);
			end
		end
	end

	always_comb begin
		req_ready = '0;
		if (load_en && grant_found)
			req_ready[grant_idx] = 1'b1;
	end

	always_ff @(posedge clk_1x or negedge arst_n) begin
		if (!arst_n) begin
			card_valid <= 1'b0;
			ptr        <= '0;
		end else if (load_en) begin
			card_valid <= grant_found;
			if (grant_found) begin
				if (grant_idx == IDX_W'(NUM_CARDS - 1))
					ptr <= '0;
				else
					ptr <= grant_idx + 1'b1;
			end
		end
	end

	// Output payload
	always_ff @(posedge clk_1x) begin
		if (load_en && grant_found) begin
			card_index <= grant_idx;
			card_op    <= req_op[grant_idx];
		end
	end

endmodule

// ==== design/memcard_slot.sv ====
// Mount state and pending requests of one memory card.
// A pending load is offered before a pending save.
// Unmounting drops any pending request, even one on offer.

module memcard_slot (
	input  logic                   clk_1x,
	input  logic                   arst_n,
	input  logic                   req_ready,
	card_event_if.slot             ev,
	output logic                   req_valid,
	output psx_host_pkg::card_op_t req_op,
	output logic                   mounted
);

	logic                   load_pend;
	logic                   save_pend;
	logic                   load_n;
	logic                   save_n;
	logic                   mounted_n;
	psx_host_pkg::card_op_t op_n;

	always_comb begin
		load_n    = load_pend;
		save_n    = save_pend;
		mounted_n = mounted;
		if (req_valid && req_ready) begin
			if (req_op == psx_host_pkg::CARD_LOAD)
				load_n = 1'b0;
			else
				save_n = 1'b0;
		end
		if (ev.mount) begin
			mounted_n = ev.image_present;
			load_n    = ev.image_present;
			if (!ev.image_present)
				save_n = 1'b0;
		end else if (mounted) begin
			if (ev.load_cmd)
				load_n = 1'b1;
			if (ev.save_cmd)
				save_n = 1'b1;
		end
		// Keep the offered opcode until it is taken
		if (req_valid && !req_ready && (req_op == psx_host_pkg::CARD_LOAD ? load_n : save_n))
			op_n = req_op;
		else
			op_n = load_n ? psx_host_pkg::CARD_LOAD : psx_host_pkg::CARD_SAVE;
	end

	always_ff @(posedge clk_1x or negedge arst_n) begin
		if (!arst_n) begin
			load_pend <= 1'b0;
			save_pend <= 1'b0;
			mounted   <= 1'b0;
			req_valid <= 1'b0;
			req_op    <= psx_host_pkg::CARD_LOAD;
		end else begin
			load_pend <= load_n;
			save_pend <= save_n;
			mounted   <= mounted_n;
			req_valid <= load_n || save_n;
			req_op    <= op_n;
		end
	end

endmodule

// ==== design/card_event_decoder.sv ====
// Turns mount pulses and menu commands into per-slot event strobes.
// Every strobe is registered and appears one cycle after its input.
// Load and save commands go to all slots at once.

module card_event_decoder #(
	parameter int NUM_CARDS = 2
) (
	input  logic                                clk_1x,
	input  logic                                arst_n,
	input  logic [NUM_CARDS-1:0]                img_mounted,
	input  logic [psx_host_pkg::IMG_SIZE_W-1:0] img_size,
	input  logic                                bk_load,
	input  logic                                bk_save,
	input  logic                                osd_open,
	input  logic                                autosave,
	card_event_if.decoder                       ev [NUM_CARDS]
);

	logic                 bk_load_q;
	logic                 bk_save_q;
	logic                 osd_open_q;
	logic [NUM_CARDS-1:0] mount_q;
	logic                 present_q;
	logic                 load_q;
	logic                 save_q;

	always_ff @(posedge clk_1x or negedge arst_n) begin
		if (!arst_n) begin
			bk_load_q  <= 1'b0;
			bk_save_q  <= 1'b0;
			osd_open_q <= 1'b0;
			mount_q    <= '0;
			present_q  <= 1'b0;
			load_q     <= 1'b0;
			save_q     <= 1'b0;
		end else begin
			bk_load_q  <= bk_load;
			bk_save_q  <= bk_save;
			osd_open_q <= osd_open;
			mount_q    <= img_mounted;
			// One size compare shared by all slots
			present_q  <= |img_size;
			load_q     <= bk_load && !bk_load_q;
			// Autosave fires when the menu opens
			save_q     <= (bk_save && !bk_save_q) || (osd_open && !osd_open_q && autosave);
		end
	end

	for (genvar i = 0; i < NUM_CARDS; i++) begin : g_ev
		assign ev[i].mount         = mount_q[i];
		assign ev[i].image_present = present_q;
		assign ev[i].load_cmd      = load_q;
		assign ev[i].save_cmd      = save_q;
	end

endmodule

// ==== design/download_packer.sv ====
// Packs 16-bit host words into 32-bit RAM writes, low half first.
// The host must not write while ioctl_wait is high and must wait one cycle
// after setting ioctl_download and ioctl_index before its first write.
// ram_valid holds with address and data until ram_ready, without limit.

module download_packer (
	input  logic                                  clk_1x,
	input  logic                                  arst_n,
	input  logic                                  ioctl_download,
	input  logic [7:0]                            ioctl_index,
	input  logic [psx_host_pkg::IOCTL_ADDR_W-1:0] ioctl_addr,
	input  logic [psx_host_pkg::IOCTL_DATA_W-1:0] ioctl_dout,
	input  logic                                  ioctl_wr,
	input  logic                                  ram_ready,
	output logic                                  ioctl_wait,
	output logic                                  ram_valid,
	output logic [psx_host_pkg::IOCTL_ADDR_W-1:0] ram_addr,
	output logic [psx_host_pkg::RAM_DATA_W-1:0]   ram_data,
	output logic                                  load_exe,
	output logic                                  has_cd,
	output logic [psx_host_pkg::IOCTL_ADDR_W-1:0] cd_size,
	output logic [psx_host_pkg::IOCTL_DATA_W-1:0] libcrypt_key
);

	psx_host_pkg::dl_kind_t kind_next;
	psx_host_pkg::dl_kind_t dl_kind;
	logic [psx_host_pkg::IOCTL_ADDR_W-1:0] base_addr;
	logic to_ram;
	logic exe_prev;
	logic host_wr;

	// Sort the download by its index
	always_comb begin
		kind_next = psx_host_pkg::DL_NONE;
		if (ioctl_download) begin
			if (ioctl_index == psx_host_pkg::IDX_BIOS)
				kind_next = psx_host_pkg::DL_BIOS;
			else if (ioctl_index == psx_host_pkg::IDX_EXE)
				kind_next = psx_host_pkg::DL_EXE;
			else if (ioctl_index[5:0] == psx_host_pkg::IDX_CD)
				kind_next = psx_host_pkg::DL_CD;
			else if (ioctl_index == psx_host_pkg::IDX_SBI)
				kind_next = psx_host_pkg::DL_SBI;
		end
	end

	always_comb begin
		case (dl_kind)
			psx_host_pkg::DL_BIOS: base_addr = psx_host_pkg::BIOS_START;
			psx_host_pkg::DL_EXE:  base_addr = psx_host_pkg::EXE_START;
			default:               base_addr = '0;
		endcase
	end

	assign to_ram = (dl_kind == psx_host_pkg::DL_BIOS) || (dl_kind == psx_host_pkg::DL_EXE) ||
		(dl_kind == psx_host_pkg::DL_CD);
	// Writes are ignored while a packed word is still pending
	assign host_wr = ioctl_wr && !ram_valid;
	assign ioctl_wait = ram_valid;

	// ========================================================================
	// Control state
	// ========================================================================
	always_ff @(posedge clk_1x or negedge arst_n) begin
		if (!arst_n) begin
			dl_kind   <= psx_host_pkg::DL_NONE;
			exe_prev  <= 1'b0;
			load_exe  <= 1'b0;
			has_cd    <= 1'b0;
			ram_valid <= 1'b0;
		end else begin
			dl_kind  <= kind_next;
			exe_prev <= (dl_kind == psx_host_pkg::DL_EXE);
			load_exe <= exe_prev && (dl_kind != psx_host_pkg::DL_EXE);
			if (dl_kind == psx_host_pkg::DL_CD && kind_next != psx_host_pkg::DL_CD)
				has_cd <= 1'b1;
			if (ram_valid && ram_ready)
				ram_valid <= 1'b0;
			else if (host_wr && to_ram && ioctl_addr[1])
				ram_valid <= 1'b1;
		end
	end

	// Word assembly, CD size and key
	always_ff @(posedge clk_1x) begin
		if (host_wr && to_ram) begin
			if (!ioctl_addr[1]) begin
				ram_data[15:0] <= ioctl_dout;
				ram_addr       <= ioctl_addr + base_addr;
			end else begin
				ram_data[31:16] <= ioctl_dout;
			end
		end
		if (dl_kind == psx_host_pkg::DL_CD && kind_next != psx_host_pkg::DL_CD)
			cd_size <= ioctl_addr;
		if (ioctl_wr && dl_kind == psx_host_pkg::DL_SBI)
			libcrypt_key <= ioctl_dout;
	end

endmodule

// ==== design/card_event_if.sv ====
// Events from the decoder to one memory-card slot.
// mount, load_cmd and save_cmd are single-cycle strobes.
// image_present is only meaningful while mount is high.

interface card_event_if;

	logic mount;
	logic image_present;
	logic load_cmd;
	logic save_cmd;

	modport decoder (
		output mount,
		output image_present,
		output load_cmd,
		output save_cmd
	);

	modport slot (
		input mount,
		input image_present,
		input load_cmd,
		input save_cmd
	);

endinterface

// ==== design/psx_host_pkg.sv ====
// Shared widths, RAM bases and host download indices for the host bridge.
// The RAM bases must fit in IOCTL_ADDR_W bits.
// A CD download matches on the lower six bits of the index only.

package psx_host_pkg;

	// ========================================================================
	// Widths
	// ========================================================================
	localparam int IOCTL_ADDR_W = 27;
	localparam int IOCTL_DATA_W = 16;
	localparam int RAM_DATA_W   = 32;
	localparam int IMG_SIZE_W   = 64;

	// RAM bases of the loaded images
	localparam logic [IOCTL_ADDR_W-1:0] BIOS_START = IOCTL_ADDR_W'(2097152);
	localparam logic [IOCTL_ADDR_W-1:0] EXE_START  = IOCTL_ADDR_W'(4194304);

	// Host download indices
	localparam logic [7:0] IDX_BIOS = 8'd0;
	localparam logic [7:0] IDX_EXE  = 8'd1;
	localparam logic [5:0] IDX_CD   = 6'd2;
	localparam logic [7:0] IDX_SBI  = 8'd250;

	// ========================================================================
	// Types
	// ========================================================================
	typedef enum logic [2:0] {
		DL_NONE,
		DL_BIOS,
		DL_EXE,
		DL_CD,
		DL_SBI
	} dl_kind_t;

	typedef enum logic {
		CARD_LOAD,
		CARD_SAVE
	} card_op_t;

endpackage
